// ==== filelist.f ====
hdl/fx2_pkg.sv
hdl/ep_link_if.sv
hdl/fx2_slave_port.sv
hdl/ep2_receiver.sv
hdl/ep6_transmitter.sv
hdl/fx2_interface.sv
tests/tb_fx2_interface.sv

// ==== tests/tb_fx2_interface.sv ====
// Testbench that runs random EP2 packets and EP6 drains through the FX2 glue against bus models
`timescale 1ns/10ps
`default_nettype none

module tb_fx2_interface;

    localparam int NUM_PORTS = 4;
    localparam int ADDR_W    = 11;

    logic                        usb_ifclk = 1'b0;
    logic                        reset;
    logic                        usb_slwr;
    logic                        usb_slrd;
    logic                        usb_sloe;
    fx2_pkg::ep_addr_t           usb_addr;
    fx2_pkg::byte_t              usb_data_in;
    fx2_pkg::byte_t              usb_data_out;
    logic                        usb_ep2_empty;
    logic                        usb_ep6_full;
    fx2_pkg::byte_t              ep2_port_data;
    logic [NUM_PORTS-1:0]        ep2_port_write;
    logic [NUM_PORTS*ADDR_W-1:0] ep6_port_addr_ins;
    logic [NUM_PORTS*ADDR_W-1:0] ep6_port_addr_outs;
    logic [NUM_PORTS*8-1:0]      ep6_port_datas;
    logic [NUM_PORTS-1:0]        ep6_port_read;

    // Bytes the FX2 still holds for EP2 with the front entry on usb_data_out
    fx2_pkg::byte_t fx2_q[$];
    // Expected EP2 port writes as {port, byte}
    logic [9:0]     exp2_q[$];
    logic [9:0]     ep2_entry;
    // Bytes waiting to enter each tracking FIFO, and bytes EP6 must still send
    fx2_pkg::byte_t load_q[NUM_PORTS][$];
    fx2_pkg::byte_t exp6_q[NUM_PORTS][$];
    fx2_pkg::byte_t fifo_mem[NUM_PORTS][2**ADDR_W];
    logic [ADDR_W-1:0] addr_in[NUM_PORTS];
    logic [ADDR_W-1:0] addr_out[NUM_PORTS];
    // Pending count per port seen at the previous falling edge, and at the last marker
    logic [ADDR_W-1:0] pend_prev[NUM_PORTS];
    logic [ADDR_W-1:0] pend_start[NUM_PORTS];

    logic [31:0]          rng_state = 32'h5b30_612d;
    logic                 run_en = 1'b0;
    logic                 rd_taken = 1'b0;
    logic [NUM_PORTS-1:0] read_seen = '0;
    logic                 wrote_turn = 1'b0;
    int                   ep6_pos = 0;
    int                   ep6_port = 0;
    int                   ep6_cnt = 0;
    fx2_pkg::len_t        ep6_len;
    int                   value_errs = 0;
    int                   other_errs = 0;

    fx2_interface #(
        .NUM_PORTS   (NUM_PORTS),
        .FIFO_ADDR_W (ADDR_W)
    ) i_dut (
        .usb_ifclk          (usb_ifclk),
        .reset              (reset),
        .usb_slwr           (usb_slwr),
        .usb_slrd           (usb_slrd),
        .usb_sloe           (usb_sloe),
        .usb_addr           (usb_addr),
        .usb_data_in        (usb_data_in),
        .usb_data_out       (usb_data_out),
        .usb_ep2_empty      (usb_ep2_empty),
        .usb_ep6_full       (usb_ep6_full),
        .ep2_port_data      (ep2_port_data),
        .ep2_port_write     (ep2_port_write),
        .ep6_port_addr_ins  (ep6_port_addr_ins),
        .ep6_port_addr_outs (ep6_port_addr_outs),
        .ep6_port_datas     (ep6_port_datas),
        .ep6_port_read      (ep6_port_read)
    );

    always #2 usb_ifclk = ~usb_ifclk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Any value but the marker so that the receiver drops it
    function automatic fx2_pkg::byte_t non_header_byte();
        return fx2_pkg::byte_t'(next_rand() % 32'd255);
    endfunction

    function automatic logic [NUM_PORTS-1:0] port_bit(input int p);
        return NUM_PORTS'(1) << p;
    endfunction

    function automatic logic all_drained();
        logic done;
        done = (fx2_q.size() == 0) && (exp2_q.size() == 0) && (ep6_pos == 0);
        for (int p = 0; p < NUM_PORTS; p++) begin
            done = done && (load_q[p].size() == 0) && (exp6_q[p].size() == 0);
        end
        return done;
    endfunction

    task automatic check_byte(input string name, input fx2_pkg::byte_t got,
                              input fx2_pkg::byte_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("ERROR %s got 0x%02h expected 0x%02h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_port(input string name, input logic [NUM_PORTS-1:0] got,
                              input logic [NUM_PORTS-1:0] exp);
        if (got !== exp) begin
            value_errs++;
            $display("ERROR %s got 0x%01h expected 0x%01h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_addr(input string name, input fx2_pkg::ep_addr_t got,
                              input fx2_pkg::ep_addr_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("ERROR %s got 0x%01h expected 0x%01h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_len(input string name, input fx2_pkg::len_t got,
                             input fx2_pkg::len_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("ERROR %s got 0x%04h expected 0x%04h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errs++;
            $display("ERROR %s got 0x%01h expected 0x%01h at %0t", name, got, exp, $time);
        end
    endtask

    // Walks one EP6 packet byte by byte through marker, port, both length bytes and data
    task automatic parse_ep6_byte(input fx2_pkg::byte_t b);
        case (ep6_pos)
            0: begin
                check_byte("usb_data_in marker", b, fx2_pkg::HEADER_BYTE);
                pend_start = pend_prev;
                ep6_pos = 1;
            end
            1: begin
                ep6_port = 0;
                if (b >= NUM_PORTS) begin
                    other_errs++;
                    $display("EP6 packet names port %0d, which does not exist", b);
                end else begin
                    ep6_port = b;
                end
                ep6_pos = 2;
            end
            2: begin
                ep6_len[15:8] = b;
                ep6_pos = 3;
            end
            3: begin
                ep6_len[7:0] = b;
                // Length must be the pointer difference when the packet opened
                check_len("ep6 packet length", ep6_len, fx2_pkg::len_t'(pend_start[ep6_port]));
                ep6_cnt = 0;
                ep6_pos = (ep6_len == 0) ? 0 : 4;
            end
            default: begin
                if (exp6_q[ep6_port].size() == 0) begin
                    other_errs++;
                    $display("EP6 sent more bytes for port %0d than were loaded", ep6_port);
                end else begin
                    check_byte("usb_data_in data", b, exp6_q[ep6_port].pop_front());
                end
                ep6_cnt++;
                if (ep6_cnt == ep6_len) begin
                    ep6_pos = 0;
                end
            end
        endcase
    endtask

    // Outputs are looked at on the falling edge half a cycle after they settle
    always @(negedge usb_ifclk) begin
        if (run_en) begin
            if (ep2_port_write != '0) begin
                if (exp2_q.size() == 0) begin
                    other_errs++;
                    $display("EP2 wrote byte 0x%02h to a port with no packet data due",
                             ep2_port_data);
                end else begin
                    ep2_entry = exp2_q.pop_front();
                    check_port("ep2_port_write", ep2_port_write, port_bit(ep2_entry[9:8]));
                    check_byte("ep2_port_data", ep2_port_data, ep2_entry[7:0]);
                end
            end
            if ((usb_addr !== fx2_pkg::EP2_ADDR) && (usb_addr !== fx2_pkg::EP6_ADDR)) begin
                value_errs++;
                $display("ERROR usb_addr got 0x%01h expected an EP2 or EP6 code", usb_addr);
            end
            if (!usb_slrd) begin
                check_addr("usb_addr during read", usb_addr, fx2_pkg::EP2_ADDR);
            end
            if (!usb_slwr) begin
                check_addr("usb_addr during write", usb_addr, fx2_pkg::EP6_ADDR);
                parse_ep6_byte(usb_data_in);
            end
            check_bit("usb_sloe", usb_sloe, 1'b0);
            rd_taken  = !usb_slrd;
            read_seen = ep6_port_read;
            for (int p = 0; p < NUM_PORTS; p++) begin
                pend_prev[p] = addr_in[p] - addr_out[p];
            end
        end
    end

    // FX2 and tracking-FIFO models step just after each rising edge
    always @(posedge usb_ifclk) begin
        #0.5;
        if (run_en) begin
            if (rd_taken) begin
                if (fx2_q.size() == 0) begin
                    other_errs++;
                    $display("EP2 read the FX2 while it held no data at %0t", $time);
                end else begin
                    void'(fx2_q.pop_front());
                end
            end
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (read_seen[p]) begin
                    if (addr_out[p] == addr_in[p]) begin
                        other_errs++;
                        $display("EP6 read tracking FIFO %0d while it was empty", p);
                    end
                    addr_out[p] = addr_out[p] + 1'b1;
                end
                // One new byte per cycle lets data arrive while a packet is open
                if (load_q[p].size() != 0) begin
                    fifo_mem[p][addr_in[p]] = load_q[p].pop_front();
                    addr_in[p] = addr_in[p] + 1'b1;
                end
                ep6_port_addr_ins[p*ADDR_W +: ADDR_W]  = addr_in[p];
                ep6_port_addr_outs[p*ADDR_W +: ADDR_W] = addr_out[p];
                ep6_port_datas[p*8 +: 8]                = fifo_mem[p][addr_out[p]];
            end
            usb_ep2_empty = (fx2_q.size() == 0) || (next_rand() % 32'd4 == 0);
            usb_data_out  = (fx2_q.size() != 0) ? fx2_q[0] : 8'h00;
            // A write that lands now was requested under the full flag still on the bus
            if (!usb_slwr && usb_ep6_full) begin
                other_errs++;
                $display("EP6 wrote to the FX2 while it reported full at %0t", $time);
            end
            // The FX2 may only report full before the first write of an EP6 turn
            if (usb_addr !== fx2_pkg::EP6_ADDR) begin
                wrote_turn = 1'b0;
            end else if (!usb_slwr) begin
                wrote_turn = 1'b1;
            end
            usb_ep6_full = !wrote_turn && (next_rand() % 32'd4 == 0);
        end
    end

    initial begin
        int n;
        int p;
        int len;
        int t;
        fx2_pkg::byte_t b;
        reset              = 1'b1;
        usb_data_out       = 8'h00;
        usb_ep2_empty      = 1'b1;
        usb_ep6_full       = 1'b0;
        ep6_port_addr_ins  = '0;
        ep6_port_addr_outs = '0;
        ep6_port_datas     = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            addr_in[i]   = '0;
            addr_out[i]  = '0;
            pend_prev[i] = '0;
        end
        repeat (4) @(posedge usb_ifclk);
        #0.5 reset = 1'b0;
        @(negedge usb_ifclk);
        check_bit("usb_slwr", usb_slwr, 1'b1);
        check_bit("usb_slrd", usb_slrd, 1'b1);
        check_bit("usb_sloe", usb_sloe, 1'b0);
        check_addr("usb_addr", usb_addr, fx2_pkg::EP2_ADDR);
        check_port("ep2_port_write", ep2_port_write, '0);
        check_port("ep6_port_read", ep6_port_read, '0);
        @(posedge usb_ifclk);
        #1 run_en = 1'b1;
        for (int round = 0; round < 4; round++) begin
            for (int k = 0; k < 8; k++) begin
                // Stray bytes ahead of a packet must be thrown away
                n = int'(next_rand() % 32'd4);
                repeat (n) fx2_q.push_back(non_header_byte());
                p   = int'(next_rand() % NUM_PORTS);
                len = 1 + int'(next_rand() % 32'd20);
                fx2_q.push_back(fx2_pkg::HEADER_BYTE);
                fx2_q.push_back(fx2_pkg::byte_t'(p));
                fx2_q.push_back(8'h00);
                fx2_q.push_back(fx2_pkg::byte_t'(len));
                repeat (len) begin
                    b = fx2_pkg::byte_t'(next_rand());
                    fx2_q.push_back(b);
                    exp2_q.push_back({p[1:0], b});
                end
            end
            for (int q = 0; q < NUM_PORTS; q++) begin
                n = int'(next_rand() % 32'd41);
                repeat (n) begin
                    b = fx2_pkg::byte_t'(next_rand());
                    load_q[q].push_back(b);
                    exp6_q[q].push_back(b);
                end
            end
            for (t = 0; (t < 4000) && !all_drained(); t++) begin
                @(posedge usb_ifclk);
                #1;
            end
            if (!all_drained()) begin
                other_errs++;
                $display("Timed out waiting for round %0d traffic to drain", round);
                break;
            end
        end
        $display("Check summary: %0d value errors, %0d other errors", value_errs, other_errs);
        if ((value_errs == 0) && (other_errs == 0)) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/fx2_interface.sv ====
// Top level of the FX2 slave FIFO data glue, joining the bus owner to the EP2 and EP6 engines
`timescale 1ns/10ps
`default_nettype none

module fx2_interface #(
    parameter int NUM_PORTS   = 4,
    parameter int FIFO_ADDR_W = 11
) (
    input  wire                                 usb_ifclk,
    input  wire                                 reset,
    // FX2 slave FIFO bus, strobes are active low
    output wire                                 usb_slwr,
    output wire                                 usb_slrd,
    output wire                                 usb_sloe,
    output wire fx2_pkg::ep_addr_t              usb_addr,
    output wire fx2_pkg::byte_t                 usb_data_in,
    input  wire fx2_pkg::byte_t                 usb_data_out,
    input  wire                                 usb_ep2_empty,
    input  wire                                 usb_ep6_full,
    // Write side of the EP2 tracking FIFOs, data is shared by all ports
    output wire fx2_pkg::byte_t                 ep2_port_data,
    output wire [NUM_PORTS-1:0]                 ep2_port_write,
    // Read side of the EP6 tracking FIFOs, packed with port 0 in the low bits
    input  wire [NUM_PORTS*FIFO_ADDR_W-1:0]     ep6_port_addr_ins,
    input  wire [NUM_PORTS*FIFO_ADDR_W-1:0]     ep6_port_addr_outs,
    input  wire [NUM_PORTS*8-1:0]               ep6_port_datas,
    output wire [NUM_PORTS-1:0]                 ep6_port_read
);

    ep_link_if link_ep2 ();
    ep_link_if link_ep6 ();

    fx2_slave_port i_slave_port (
        .usb_ifclk     (usb_ifclk),
        .reset         (reset),
        .usb_ep2_empty (usb_ep2_empty),
        .usb_data_out  (usb_data_out),
        .usb_slrd      (usb_slrd),
        .usb_sloe      (usb_sloe),
        .usb_slwr      (usb_slwr),
        .usb_addr      (usb_addr),
        .usb_data_in   (usb_data_in),
        .link_ep2      (link_ep2.port),
        .link_ep6      (link_ep6.port)
    );

    ep2_receiver #(
        .NUM_PORTS      (NUM_PORTS)
    ) i_ep2 (
        .usb_ifclk      (usb_ifclk),
        .reset          (reset),
        .link           (link_ep2.engine),
        .ep2_port_data  (ep2_port_data),
        .ep2_port_write (ep2_port_write)
    );

    ep6_transmitter #(
        .NUM_PORTS          (NUM_PORTS),
        .FIFO_ADDR_W        (FIFO_ADDR_W)
    ) i_ep6 (
        .usb_ifclk          (usb_ifclk),
        .reset              (reset),
        .link               (link_ep6.engine),
        .usb_ep6_full       (usb_ep6_full),
        .ep6_port_addr_ins  (ep6_port_addr_ins),
        .ep6_port_addr_outs (ep6_port_addr_outs),
        .ep6_port_datas     (ep6_port_datas),
        .ep6_port_read      (ep6_port_read)
    );

endmodule

`default_nettype wire

// ==== hdl/ep6_transmitter.sv ====
// EP6 packet builder that visits the tracking FIFOs round-robin and drains pending bytes to the FX2
`timescale 1ns/10ps
`default_nettype none

module ep6_transmitter #(
    parameter int NUM_PORTS   = 4,
    parameter int FIFO_ADDR_W = 11
) (
    input  wire                                 usb_ifclk,
    input  wire                                 reset,
    ep_link_if.engine                           link,
    input  wire                                 usb_ep6_full,
    input  wire [NUM_PORTS*FIFO_ADDR_W-1:0]     ep6_port_addr_ins,
    input  wire [NUM_PORTS*FIFO_ADDR_W-1:0]     ep6_port_addr_outs,
    input  wire [NUM_PORTS*8-1:0]               ep6_port_datas,
    output logic [NUM_PORTS-1:0]                ep6_port_read
);

    localparam int PORT_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

    fx2_pkg::packet_state_t state;
    // Tracking FIFO currently being looked at or drained
    logic [PORT_W-1:0]      port_idx;
    logic [PORT_W-1:0]      port_next;
    fx2_pkg::len_t          length;
    // Data bytes already handed to the slave port
    fx2_pkg::len_t          count;
    logic [FIFO_ADDR_W-1:0] cur_in;
    logic [FIFO_ADDR_W-1:0] cur_out;
    // Pointer difference that wraps at the pointer width
    logic [FIFO_ADDR_W-1:0] pending_len;
    logic                   pending;
    logic                   start;
    logic                   skip;
    logic                   read_en;

    // Pointers and data of the selected tracking FIFO
    assign cur_in      = ep6_port_addr_ins[port_idx*FIFO_ADDR_W +: FIFO_ADDR_W];
    assign cur_out     = ep6_port_addr_outs[port_idx*FIFO_ADDR_W +: FIFO_ADDR_W];
    assign pending_len = cur_in - cur_out;
    assign pending     = (cur_in != cur_out);

    assign port_next = (port_idx == PORT_W'(NUM_PORTS - 1)) ? '0 : port_idx + 1'b1;

    // Back-pressure is only looked at before a packet opens
    assign start = link.grant && (state == fx2_pkg::WAITING) && !usb_ep6_full && pending;
    assign skip  = link.grant && (state == fx2_pkg::WAITING) && !usb_ep6_full && !pending;

    // Every state except WAITING without data and DONE pushes one byte per cycle
    assign link.req = start || ((state != fx2_pkg::WAITING) && (state != fx2_pkg::DONE));

    // DONE is a quiet cycle so the last write clears the bus before EP2 reads
    assign link.release_turn = link.grant && (((state == fx2_pkg::WAITING) && !start) ||
                                              (state == fx2_pkg::DONE));

    always_comb begin
        case (state)
            fx2_pkg::HEADER_PORT: link.tx_byte = fx2_pkg::byte_t'(port_idx);
            fx2_pkg::LENGTH_HIGH: link.tx_byte = length[15:8];
            fx2_pkg::LENGTH_LOW:  link.tx_byte = length[7:0];
            fx2_pkg::DATA:        link.tx_byte = ep6_port_datas[port_idx*8 +: 8];
            default:              link.tx_byte = fx2_pkg::HEADER_BYTE;
        endcase
    end

    // The read pointer moves in the same cycle its byte is taken
    assign read_en = link.xfer && (state == fx2_pkg::DATA);

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port_read
        assign ep6_port_read[p] = read_en && (port_idx == p);
    end

    always_ff @(posedge usb_ifclk) begin
        if (reset) begin
            state    <= fx2_pkg::WAITING;
            port_idx <= '0;
        end else begin
            case (state)
                fx2_pkg::WAITING: begin
                    // A full FX2 keeps the same port for the next visit
                    if (start) begin
                        state <= fx2_pkg::HEADER_PORT;
                    end else if (skip) begin
                        port_idx <= port_next;
                    end
                end
                fx2_pkg::HEADER_PORT: if (link.xfer) state <= fx2_pkg::LENGTH_HIGH;
                fx2_pkg::LENGTH_HIGH: if (link.xfer) state <= fx2_pkg::LENGTH_LOW;
                fx2_pkg::LENGTH_LOW:  if (link.xfer) state <= fx2_pkg::DATA;
                fx2_pkg::DATA: begin
                    if (link.xfer && (count == length - 16'd1)) begin
                        state <= fx2_pkg::DONE;
                    end
                end
                fx2_pkg::DONE: begin
                    if (link.grant) begin
                        port_idx <= port_next;
                        state    <= fx2_pkg::WAITING;
                    end
                end
                default: state <= fx2_pkg::WAITING;
            endcase
        end
    end

    // Length is frozen when the packet opens so that later arrivals wait for the next visit
    always_ff @(posedge usb_ifclk) begin
        if (start) begin
            length <= fx2_pkg::len_t'(pending_len);
            count  <= '0;
        end else if (read_en) begin
            count <= count + 16'd1;
        end
    end

    // The drain must stop at the latched length and never run past the write pointer
    a_read_only_pending: assert property (
        @(posedge usb_ifclk) disable iff (reset)
        (ep6_port_read != '0) |-> pending
    ) else $error("EP6 read a tracking FIFO that held no data");

    // The slave port must not take the bus away while a packet is open
    a_grant_held_in_packet: assert property (
        @(posedge usb_ifclk) disable iff (reset)
        (state != fx2_pkg::WAITING) && (state != fx2_pkg::DONE) |-> link.grant
    ) else $error("EP6 lost the bus in the middle of a packet");

endmodule

`default_nettype wire

// ==== hdl/ep2_receiver.sv ====
// EP2 packet parser that steers each inbound data byte to the write strobe of its tracking FIFO
`timescale 1ns/10ps
`default_nettype none

module ep2_receiver #(
    parameter int NUM_PORTS = 4
) (
    input  wire                     usb_ifclk,
    input  wire                     reset,
    ep_link_if.engine               link,
    output fx2_pkg::byte_t          ep2_port_data,
    output logic [NUM_PORTS-1:0]    ep2_port_write
);

    localparam int PORT_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

    fx2_pkg::packet_state_t state;
    // Port chosen by the header, and whether that index exists at all
    logic [PORT_W-1:0]      port_sel;
    logic                   port_valid;
    fx2_pkg::len_t          length;
    // Data bytes already passed to the tracking FIFO
    fx2_pkg::len_t          count;
    // Full length once the low byte is on the bus
    fx2_pkg::len_t          rx_length;
    logic                   mid_packet;
    logic                   data_xfer;

    assign rx_length  = {length[15:8], link.rx_byte};
    assign mid_packet = (state == fx2_pkg::HEADER_PORT) || (state == fx2_pkg::LENGTH_HIGH) ||
                        (state == fx2_pkg::LENGTH_LOW) || (state == fx2_pkg::DATA);
    assign data_xfer  = link.xfer && (state == fx2_pkg::DATA);

    // Reads are wanted everywhere except while handing the turn back
    assign link.req = (state != fx2_pkg::DONE);

    // An empty FX2 in the middle of a packet parks the state and gives up the turn
    assign link.release_turn = link.grant && ((state == fx2_pkg::DONE) ||
                                              (mid_packet && !link.xfer));

    // The receiver never writes to the FX2
    assign link.tx_byte = '0;

    // Data bytes go straight through in the cycle they are read
    assign ep2_port_data = link.rx_byte;

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port_write
        assign ep2_port_write[p] = data_xfer && port_valid && (port_sel == p);
    end

    always_ff @(posedge usb_ifclk) begin
        if (reset) begin
            state <= fx2_pkg::WAITING;
        end else begin
            case (state)
                fx2_pkg::WAITING: begin
                    // Anything but a marker, or no byte at all, ends this turn
                    if (link.grant) begin
                        if (link.xfer && (link.rx_byte == fx2_pkg::HEADER_BYTE)) begin
                            state <= fx2_pkg::HEADER_PORT;
                        end else begin
                            state <= fx2_pkg::DONE;
                        end
                    end
                end
                fx2_pkg::HEADER_PORT: begin
                    if (link.xfer) begin
                        state <= fx2_pkg::LENGTH_HIGH;
                    end
                end
                fx2_pkg::LENGTH_HIGH: begin
                    if (link.xfer) begin
                        state <= fx2_pkg::LENGTH_LOW;
                    end
                end
                fx2_pkg::LENGTH_LOW: begin
                    // An empty packet has no data phase
                    if (link.xfer) begin
                        state <= (rx_length == '0) ? fx2_pkg::DONE : fx2_pkg::DATA;
                    end
                end
                fx2_pkg::DATA: begin
                    if (link.xfer && (count == length - 16'd1)) begin
                        state <= fx2_pkg::DONE;
                    end
                end
                fx2_pkg::DONE: begin
                    if (link.grant) begin
                        state <= fx2_pkg::WAITING;
                    end
                end
                default: state <= fx2_pkg::WAITING;
            endcase
        end
    end

    // Header fields and the byte count follow the bytes actually read
    always_ff @(posedge usb_ifclk) begin
        if (link.xfer) begin
            case (state)
                fx2_pkg::HEADER_PORT: begin
                    port_sel   <= link.rx_byte[PORT_W-1:0];
                    port_valid <= (link.rx_byte < NUM_PORTS);
                end
                fx2_pkg::LENGTH_HIGH: length[15:8] <= link.rx_byte;
                fx2_pkg::LENGTH_LOW: begin
                    length[7:0] <= link.rx_byte;
                    count       <= '0;
                end
                fx2_pkg::DATA: count <= count + 16'd1;
                default: ;
            endcase
        end
    end

    // A byte handed over in DONE or outside the turn would be lost to every port
    a_read_only_on_request: assert property (
        @(posedge usb_ifclk) disable iff (reset)
        link.xfer |-> (link.grant && link.req)
    ) else $error("EP2 byte taken without a granted read request");

endmodule

`default_nettype wire

// ==== hdl/fx2_slave_port.sv ====
// Owner of the FX2 slave FIFO bus that passes the turn between the EP2 and EP6 engines
`timescale 1ns/10ps
`default_nettype none

module fx2_slave_port (
    input  wire                     usb_ifclk,
    input  wire                     reset,
    input  wire                     usb_ep2_empty,
    input  wire fx2_pkg::byte_t     usb_data_out,
    output logic                    usb_slrd,
    output logic                    usb_sloe,
    output logic                    usb_slwr,
    output fx2_pkg::ep_addr_t       usb_addr,
    output fx2_pkg::byte_t          usb_data_in,
    ep_link_if.port                 link_ep2,
    ep_link_if.port                 link_ep6
);

    // Endpoint that currently owns the bus, which is also the FIFOADR value
    fx2_pkg::ep_addr_t turn;

    // Only the engine whose endpoint is selected may act
    assign link_ep2.grant = (turn == fx2_pkg::EP2_ADDR);
    assign link_ep6.grant = (turn == fx2_pkg::EP6_ADDR);

    // The turn flips at the edge that follows a release from its owner
    always_ff @(posedge usb_ifclk) begin
        if (reset) begin
            turn <= fx2_pkg::EP2_ADDR;
        end else if (link_ep2.grant && link_ep2.release_turn) begin
            turn <= fx2_pkg::EP6_ADDR;
        end else if (link_ep6.grant && link_ep6.release_turn) begin
            turn <= fx2_pkg::EP2_ADDR;
        end
    end

    assign usb_addr = turn;

    // The FX2 keeps driving its data lines at all times
    assign usb_sloe = 1'b0;

    // A read happens only when EP2 asks for one and the FX2 has data
    assign link_ep2.xfer = link_ep2.grant && link_ep2.req && !usb_ep2_empty;
    assign usb_slrd      = !link_ep2.xfer;

    // Both engines see the FX2 output byte, only EP2 consumes it
    assign link_ep2.rx_byte = usb_data_out;
    assign link_ep6.rx_byte = usb_data_out;

    // An EP6 write request is always taken, the byte goes out on the next cycle
    assign link_ep6.xfer = link_ep6.grant && link_ep6.req;

    // Write strobe is registered together with its data byte
    always_ff @(posedge usb_ifclk) begin
        if (reset) begin
            usb_slwr <= 1'b1;
        end else begin
            usb_slwr <= !link_ep6.xfer;
        end
    end

    always_ff @(posedge usb_ifclk) begin
        usb_data_in <= link_ep6.tx_byte;
    end

    // The EP6 engine must idle for a cycle before it releases, or its last
    // registered write would overlap the first EP2 read
    a_no_read_write_overlap: assert property (
        @(posedge usb_ifclk) disable iff (reset)
        !(!usb_slrd && !usb_slwr)
    ) else $error("usb_slrd and usb_slwr both low");

endmodule

`default_nettype wire

// ==== hdl/ep_link_if.sv ====
// Link between the FX2 bus owner and one endpoint engine, instanced once per endpoint
`timescale 1ns/10ps
`default_nettype none

interface ep_link_if;

    // High while this engine owns the FX2 bus
    logic grant;
    // One-cycle pulse from the engine that ends its turn at the next edge
    logic release_turn;
    // Read request on EP2, write request on EP6
    logic req;
    // A byte crosses the FX2 bus in this cycle
    logic xfer;
    // Byte currently presented by the FX2 on usb_data_out
    fx2_pkg::byte_t rx_byte;
    // Byte the engine wants written to the FX2
    fx2_pkg::byte_t tx_byte;

    // Bus owner side
    modport port (
        output grant, xfer, rx_byte,
        input  release_turn, req, tx_byte
    );

    // Endpoint engine side
    modport engine (
        input  grant, xfer, rx_byte,
        output release_turn, req, tx_byte
    );

endinterface

`default_nettype wire

// ==== hdl/fx2_pkg.sv ====
// Shared FX2 types, endpoint codes and packet states, referenced by scoped name from every RTL file
`default_nettype none

package fx2_pkg;

    // One byte on the FX2 slave FIFO data bus
    typedef logic [7:0] byte_t;

    // Packet length as carried in the two header length bytes
    typedef logic [15:0] len_t;

    // FIFOADR code that selects an FX2 endpoint buffer
    typedef logic [1:0] ep_addr_t;

    // Endpoint codes on usb_addr
    // EP2 is the host-to-device data endpoint
    localparam ep_addr_t EP2_ADDR = 2'd0;
    // EP6 is the device-to-host data endpoint
    localparam ep_addr_t EP6_ADDR = 2'd2;

    // Every packet in both directions opens with this marker byte
    localparam byte_t HEADER_BYTE = 8'hFF;

    // Packet walk shared by the receiver and the transmitter
    // The header is marker, port index, length high, length low
    typedef enum logic [2:0] {
        // Looking for the marker byte, or deciding whether to send one
        WAITING,
        // Port index byte is next
        HEADER_PORT,
        // Upper length byte is next
        LENGTH_HIGH,
        // Lower length byte is next
        LENGTH_LOW,
        // Payload bytes until the length is used up
        DATA,
        // Turn is handed back to the other endpoint
        DONE
    } packet_state_t;

endpackage

`default_nettype wire
